// File: rob_pkg.sv
`default_nettype none

package rob_pkg;

    // Major opcodes and funct7 seen by the decoder
    localparam logic [6:0] opc_reg       = 7'b0110011; // R-type, shared by mul and div
    localparam logic [6:0] opc_branch    = 7'b1100011;
    localparam logic [6:0] opc_store     = 7'b0100011;
    localparam logic [6:0] funct7_muldiv = 7'b0000001; // M extension

    typedef enum logic [2:0] {
        op_alu    = 3'd0,
        op_mul    = 3'd1,
        op_div    = 3'd2,
        op_branch = 3'd3,
        op_store  = 3'd4
    } opcode_e;

    typedef struct packed {
        logic        valid;     // Low for a bubble
        opcode_e     opcode;
        logic        reg_write;
        logic [4:0]  dest;      // rd field
        logic [31:0] pc;
        logic [31:0] instr;
    } dispatch_t;

    typedef struct packed {
        logic        valid;
        logic        ready;     // Result has arrived
        logic        reg_write;
        logic        is_branch;
        logic [4:0]  dest;
        logic [31:0] value;     // Result, or target for a branch
        logic [31:0] pc;        // Tag used by completions
        logic [31:0] instr;
    } rob_entry_t;

    typedef struct packed {
        logic        done;      // One-cycle strobe
        logic [31:0] value;
        logic [31:0] pc;
    } exec_result_t;

    typedef struct packed {
        logic        taken;     // One-cycle strobe
        logic [31:0] branch_pc;
        logic [31:0] target;
    } redirect_t;

    typedef struct packed {
        logic        valid;     // High for one cycle per retirement
        logic        reg_write;
        logic        is_branch;
        logic [4:0]  dest;
        logic [31:0] value;
        logic [31:0] pc;
    } commit_t;

endpackage

`default_nettype wire

// File: rob_dispatch.sv
`default_nettype none

module rob_dispatch (
    input  wire logic          clk,
    input  wire logic          rst,
    input  wire logic [31:0]   instr,
    input  wire logic [31:0]   pc,
    output rob_pkg::dispatch_t disp
);

    logic [6:0]         major;
    logic [2:0]         funct3;
    logic [6:0]         funct7;
    logic [4:0]         rd;
    logic               not_bubble;
    logic               writes_rd;
    rob_pkg::opcode_e   op_class;
    rob_pkg::dispatch_t disp_next;

    assign major      = instr[6:0];
    assign funct3     = instr[14:12];
    assign funct7     = instr[31:25];
    assign rd         = instr[11:7];
    assign not_bubble = |instr; // All-zero word is a bubble

    // Instruction class from the major opcode
    always_comb begin
        if (major == rob_pkg::opc_reg && funct7 == rob_pkg::funct7_muldiv) begin
            if (funct3 < 3'd4) begin
                op_class = rob_pkg::op_mul; // mul, mulh, mulhsu, mulhu
            end else begin
                op_class = rob_pkg::op_div; // div, divu, rem, remu
            end
        end else if (major == rob_pkg::opc_branch) begin
            op_class = rob_pkg::op_branch;
        end else if (major == rob_pkg::opc_store) begin
            op_class = rob_pkg::op_store;
        end else begin
            op_class = rob_pkg::op_alu;
        end
    end

    // Branches and stores never write a register, nor does rd = x0
    assign writes_rd = (op_class != rob_pkg::op_branch)
                    && (op_class != rob_pkg::op_store)
                    && (rd != 5'd0);

    always_comb begin
        disp_next.valid     = not_bubble;
        disp_next.opcode    = op_class;
        disp_next.reg_write = not_bubble && writes_rd;
        disp_next.dest      = rd;
        disp_next.pc        = pc;
        disp_next.instr     = instr;
    end

    // One-cycle register stage towards the buffer
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            disp <= '0;
        end else begin
            disp <= disp_next;
        end
    end

endmodule

`default_nettype wire

// File: reorder_buffer.sv
`default_nettype none

module reorder_buffer #(
    parameter int depth = 16 // Power of two
) (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire rob_pkg::dispatch_t    disp,
    input  wire rob_pkg::exec_result_t alu_res,
    input  wire rob_pkg::exec_result_t mul_res,
    input  wire rob_pkg::exec_result_t div_res,
    input  wire rob_pkg::redirect_t    redirect,
    output logic                       full,
    output rob_pkg::rob_entry_t        head_entry,
    output logic                       retire
);

    localparam int idx_w = $clog2(depth);

    rob_pkg::rob_entry_t slots [depth];

    logic [idx_w:0]   head;       // Extra bit tells full from empty
    logic [idx_w:0]   tail;
    logic [idx_w-1:0] head_idx;
    logic [idx_w-1:0] tail_idx;
    logic             flush_hit;  // Redirect found its branch
    logic [idx_w-1:0] flush_idx;
    logic [idx_w:0]   flush_tail;
    logic [depth-1:0] kill_mask;  // Slots younger than the branch
    logic             do_write;

    // A completion lands on a valid slot that is still waiting on this pc
    function automatic logic res_hit(input rob_pkg::exec_result_t res,
                                     input rob_pkg::rob_entry_t   e);
        return res.done && e.valid && !e.ready && (res.pc == e.pc);
    endfunction

    assign head_idx   = head[idx_w-1:0];
    assign tail_idx   = tail[idx_w-1:0];
    assign full       = (head[idx_w] != tail[idx_w]) && (head_idx == tail_idx);
    assign head_entry = slots[head_idx];
    assign retire     = head_entry.valid && head_entry.ready;

    // Redirect takes priority over a dispatch at the same edge
    assign do_write = disp.valid && !full && !flush_hit;

    // Walk from the head in program order to find the branch
    always_comb begin
        logic [idx_w-1:0] idx;
        flush_hit  = 1'b0;
        flush_idx  = '0;
        flush_tail = tail;
        kill_mask  = '0;
        for (int k = 0; k < depth; k++) begin
            idx = head_idx + idx_w'(k);
            if (flush_hit) begin
                kill_mask[idx] = 1'b1; // Everything after the branch
            end else if (redirect.taken && slots[idx].valid && slots[idx].is_branch
                         && !slots[idx].ready
                         && (slots[idx].pc == redirect.branch_pc)) begin
                flush_hit  = 1'b1;
                flush_idx  = idx;
                flush_tail = head + (idx_w + 1)'(k + 1);
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            head <= '0;
            tail <= '0;
            for (int i = 0; i < depth; i++) begin
                slots[i] <= '0;
            end
        end else begin
            // Completions match on the slots as they stand before this edge
            for (int i = 0; i < depth; i++) begin
                if (res_hit(alu_res, slots[i])) begin
                    slots[i].value <= alu_res.value;
                    slots[i].ready <= 1'b1;
                end
                if (res_hit(mul_res, slots[i])) begin
                    slots[i].value <= mul_res.value;
                    slots[i].ready <= 1'b1;
                end
                if (res_hit(div_res, slots[i])) begin
                    slots[i].value <= div_res.value;
                    slots[i].ready <= 1'b1;
                end
            end

            if (do_write) begin
                slots[tail_idx] <= '{
                    valid:     1'b1,
                    ready:     1'b0,
                    reg_write: disp.reg_write,
                    is_branch: disp.opcode == rob_pkg::op_branch,
                    dest:      disp.dest,
                    value:     32'd0,
                    pc:        disp.pc,
                    instr:     disp.instr
                };
            end

            if (flush_hit) begin
                slots[flush_idx].value <= redirect.target; // Branch result is its target
                slots[flush_idx].ready <= 1'b1;
                for (int i = 0; i < depth; i++) begin
                    if (kill_mask[i]) begin
                        slots[i].valid <= 1'b0;
                    end
                end
                tail <= flush_tail;
            end else if (do_write) begin
                tail <= tail + 1'b1;
            end

            if (retire) begin
                slots[head_idx].valid <= 1'b0;
                head <= head + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: rob_commit.sv
`default_nettype none

module rob_commit (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire rob_pkg::rob_entry_t head_entry,
    input  wire logic                retire,
    input  wire logic [4:0]          rd_addr,
    output rob_pkg::commit_t         commit,
    output logic [31:0]              rd_data
);

    logic [31:0] regs [1:31]; // x0 is not stored
    logic        wr_en;

    // Write only for a retiring entry with a real destination
    assign wr_en = retire && head_entry.reg_write && (head_entry.dest != 5'd0);

    // Architectural register file
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (wr_en) begin
            regs[head_entry.dest] <= head_entry.value;
        end
    end

    // Commit report, valid for one cycle per retirement
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            commit <= '0;
        end else begin
            commit.valid <= retire;
            if (retire) begin
                commit.reg_write <= head_entry.reg_write;
                commit.is_branch <= head_entry.is_branch;
                commit.dest      <= head_entry.dest;
                commit.value     <= head_entry.value;
                commit.pc        <= head_entry.pc;
            end
        end
    end

    // Combinational read port
    always_comb begin
        if (rd_addr == 5'd0) begin
            rd_data = 32'd0; // Hardwired zero
        end else begin
            rd_data = regs[rd_addr];
        end
    end

endmodule

`default_nettype wire

// File: rob_core_top.sv
`default_nettype none

module rob_core_top #(
    parameter int depth = 16 // Buffer entries, power of two
) (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic [31:0]           instr,    // Zero word is a bubble
    input  wire logic [31:0]           pc,
    input  wire rob_pkg::exec_result_t alu_res,
    input  wire rob_pkg::exec_result_t mul_res,
    input  wire rob_pkg::exec_result_t div_res,
    input  wire rob_pkg::redirect_t    redirect,
    input  wire logic [4:0]            rd_addr,
    output logic                       full,     // Supplier sends bubbles while high
    output rob_pkg::commit_t           commit,
    output logic [31:0]                rd_data
);

    rob_pkg::dispatch_t  disp;
    rob_pkg::rob_entry_t head_entry;
    logic                retire;

    rob_dispatch rob_dispatch_inst (
        .clk   (clk),
        .rst   (rst),
        .instr (instr),
        .pc    (pc),
        .disp  (disp)
    );

    reorder_buffer #(
        .depth (depth)
    ) reorder_buffer_inst (
        .clk        (clk),
        .rst        (rst),
        .disp       (disp),
        .alu_res    (alu_res),
        .mul_res    (mul_res),
        .div_res    (div_res),
        .redirect   (redirect),
        .full       (full),
        .head_entry (head_entry),
        .retire     (retire)
    );

    rob_commit rob_commit_inst (
        .clk        (clk),
        .rst        (rst),
        .head_entry (head_entry),
        .retire     (retire),
        .rd_addr    (rd_addr),
        .commit     (commit),
        .rd_data    (rd_data)
    );

endmodule

`default_nettype wire

// File: rob_core_chk.sv
`default_nettype none

module rob_core_chk #(
    parameter int depth = 16
) (
    input wire logic                   clk,
    input wire logic                   rst,
    input wire rob_pkg::dispatch_t     disp,
    input wire logic                   full,
    input wire logic                   retire,
    input wire rob_pkg::rob_entry_t    head_entry,
    input wire rob_pkg::rob_entry_t    slots [depth],
    input wire logic [$clog2(depth):0] head,
    input wire logic [$clog2(depth):0] tail,
    input wire logic                   flush_hit,
    input wire logic                   commit_valid
);

    localparam int idx_w = $clog2(depth);

    int unsigned      fails = 0;  // Failed assertions so far
    logic [idx_w:0]   used;       // Occupied slots
    logic [depth-1:0] stale;      // Valid slot outside head..tail

    assign used = tail - head;

    always_comb begin
        logic [idx_w-1:0] offset;
        for (int i = 0; i < depth; i++) begin
            offset   = idx_w'(i) - head[idx_w-1:0]; // Age from the head
            stale[i] = slots[i].valid && ({1'b0, offset} >= used);
        end
    end

    a_no_dispatch_full: assert property (@(posedge clk) disable iff (rst)
        !(disp.valid && full))
        else begin
            $error("Non-bubble dispatch while the buffer is full");
            fails++;
        end

    // The head slot must hold a live entry when it retires
    a_retire_ready: assert property (@(posedge clk) disable iff (rst)
        retire |-> (used != '0))
        else begin
            $error("Retire from a head slot while the buffer holds no entry");
            fails++;
        end

    a_quiet_reset: assert property (@(posedge clk) rst |-> !commit_valid)
        else begin
            $error("Commit reported during reset");
            fails++;
        end

    a_flush_clean: assert property (@(posedge clk) disable iff (rst)
        flush_hit |=> (stale == '0))
        else begin
            $error("Valid slot left past the tail after a redirect");
            fails++;
        end

endmodule

`default_nettype wire

// File: tb_rob_core.sv
`default_nettype none

module tb_rob_core;

    localparam int depth   = 16;
    localparam int n_fixed = 14;
    localparam int n_rows  = n_fixed + depth;
    localparam int limit   = 100; // Cycles allowed per wait

    localparam logic [1:0] u_alu    = 2'd0;
    localparam logic [1:0] u_mul    = 2'd1;
    localparam logic [1:0] u_div    = 2'd2;
    localparam logic [1:0] u_branch = 2'd3; // Resolved through redirect

    typedef struct packed {
        logic [31:0] word;
        logic [31:0] pc;
        logic [1:0]  unit;
        logic [31:0] value;     // Target for a branch
        logic [4:0]  dest;
        logic        reg_write;
        logic        squashed;  // Killed by a taken branch
    } row_t;

    logic                  clk;
    logic                  rst;
    logic [31:0]           instr;
    logic [31:0]           pc;
    rob_pkg::exec_result_t alu_res;
    rob_pkg::exec_result_t mul_res;
    rob_pkg::exec_result_t div_res;
    rob_pkg::redirect_t    redirect;
    logic [4:0]            rd_addr;
    logic                  full;
    rob_pkg::commit_t      commit;
    logic [31:0]           rd_data;

    row_t             rows [n_rows];
    rob_pkg::commit_t exp_q [$];     // Commits still owed, oldest first
    logic [31:0]      exp_regs [32];
    logic [15:0]      lfsr;

    rob_core_top #(.depth(depth)) rob_core_top_inst (.*);

    bind reorder_buffer rob_core_chk #(.depth(depth)) rob_core_chk_inst (
        .clk          (clk),
        .rst          (rst),
        .disp         (disp),
        .full         (full),
        .retire       (retire),
        .head_entry   (head_entry),
        .slots        (slots),
        .head         (head),
        .tail         (tail),
        .flush_hit    (flush_hit),
        .commit_valid (rob_core_top.commit.valid)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] encode_word(input logic [6:0] funct7,
                                                input logic [2:0] funct3,
                                                input logic [4:0] rd,
                                                input logic [6:0] opc);
        return {funct7, 5'd2, 5'd1, funct3, rd, opc}; // rs1 = x1, rs2 = x2
    endfunction

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output int unsigned r);
        r = 0;
        for (int b = 0; b < n; b++) begin
            r    = (r << 1) | lfsr[15];
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic stop_run();
        $display("Some tests failed");
        $fatal(1, "Stopping at the first error");
    endtask

    task automatic check_commit(input rob_pkg::commit_t got, input rob_pkg::commit_t exp);
        if (got !== exp) begin
            $display("FAILED at time %0t: commit pc %h value %h dest %0d wr %b br %b",
                     $time, got.pc, got.value, got.dest, got.reg_write, got.is_branch);
            $display("    expected pc %h value %h dest %0d wr %b br %b",
                     exp.pc, exp.value, exp.dest, exp.reg_write, exp.is_branch);
            stop_run();
        end
    endtask

    task automatic check_reg(input logic [31:0] got, input logic [31:0] exp, input int idx);
        if (got !== exp) begin
            $display("FAILED at time %0t: x%0d reads %h, expected %h", $time, idx, got, exp);
            stop_run();
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("FAILED at time %0t: %s is %b, expected %b", $time, what, got, exp);
            stop_run();
        end
    endtask

    // Commit stream monitor
    always @(negedge clk) begin
        if (commit.valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("A commit for pc %h arrived when none was expected", commit.pc);
                stop_run();
            end else begin
                check_commit(commit, exp_q.pop_front());
            end
        end
    end

    // Any bound assertion failure ends the run
    always @(negedge clk) begin
        if (rob_core_top_inst.reorder_buffer_inst.rob_core_chk_inst.fails != 0) begin
            $display("A bound assertion on the reorder buffer failed");
            stop_run();
        end
    end

    task automatic present(input logic [31:0] word, input logic [31:0] addr);
        @(negedge clk);
        instr = word;
        pc    = addr;
    endtask

    task automatic expect_row(input int r);
        rob_pkg::commit_t c;
        c.valid     = 1'b1;
        c.reg_write = rows[r].reg_write;
        c.is_branch = rows[r].unit == u_branch;
        c.dest      = rows[r].dest;
        c.value     = rows[r].value;
        c.pc        = rows[r].pc;
        exp_q.push_back(c);
        if (rows[r].reg_write) begin
            exp_regs[rows[r].dest] = rows[r].value;
        end
    endtask

    // One-cycle strobe from the unit named in the row
    task automatic complete(input int r);
        @(negedge clk);
        case (rows[r].unit)
            u_alu:   alu_res = '{done: 1'b1, value: rows[r].value, pc: rows[r].pc};
            u_mul:   mul_res = '{done: 1'b1, value: rows[r].value, pc: rows[r].pc};
            u_div:   div_res = '{done: 1'b1, value: rows[r].value, pc: rows[r].pc};
            default: redirect = '{taken: 1'b1, branch_pc: rows[r].pc, target: rows[r].value};
        endcase
        @(negedge clk);
        alu_res  = '0;
        mul_res  = '0;
        div_res  = '0;
        redirect = '0;
    endtask

    task automatic complete_shuffled(input int lo, input int hi);
        int          order [$];
        int unsigned pick;
        int          j;
        int          tmp;
        for (int r = lo; r <= hi; r++) begin
            if (!rows[r].squashed) begin
                order.push_back(r);
            end
        end
        for (int i = order.size() - 1; i > 0; i--) begin
            take_bits(8, pick);
            j        = pick % (i + 1);
            tmp      = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        foreach (order[k]) begin
            complete(order[k]);
        end
    endtask

    task automatic wait_queue(input int left);
        int cycles;
        cycles = 0;
        while (exp_q.size() > left) begin
            if (cycles == limit) begin
                $display("Timed out with %0d commits still missing", exp_q.size() - left);
                stop_run();
            end
            @(negedge clk);
            cycles++;
        end
    endtask

    task automatic dispatch_rows(input int lo, input int hi, input bit gaps);
        for (int r = lo; r <= hi; r++) begin
            present(rows[r].word, rows[r].pc);
            if (!rows[r].squashed) begin
                expect_row(r);
            end
            if (gaps) begin
                present(32'd0, rows[r].pc + 32'd2); // Bubble with a live pc
            end
        end
        present(32'd0, 32'd0);
        present(32'd0, 32'd0); // Last row now sits in its slot
    endtask

    // Address driven at a falling edge, data read one cycle later
    task automatic check_all_regs();
        for (int i = 0; i < 32; i++) begin
            rd_addr = 5'(i);
            @(negedge clk);
            check_reg(rd_data, exp_regs[i], i);
        end
    endtask

    task automatic fill_table();
        rows[0]  = '{encode_word(7'h00, 3'd0, 5'd5, 7'h33), 32'h1000, u_alu, 32'h11, 5'd5, 1'b1, 1'b0};
        rows[1]  = '{encode_word(7'h01, 3'd0, 5'd6, 7'h33), 32'h1004, u_mul, 32'h22, 5'd6, 1'b1, 1'b0};
        rows[2]  = '{encode_word(7'h01, 3'd4, 5'd7, 7'h33), 32'h1008, u_div, 32'h33, 5'd7, 1'b1, 1'b0};
        rows[3]  = '{encode_word(7'h00, 3'd2, 5'd8, 7'h23), 32'h100c, u_alu, 32'h44, 5'd8, 1'b0, 1'b0};
        rows[4]  = '{encode_word(7'h00, 3'd0, 5'd0, 7'h13), 32'h1010, u_alu, 32'h55, 5'd0, 1'b0, 1'b0};
        rows[5]  = '{encode_word(7'h01, 3'd3, 5'd5, 7'h33), 32'h1014, u_mul, 32'h66, 5'd5, 1'b1, 1'b0};
        rows[6]  = '{encode_word(7'h01, 3'd7, 5'd9, 7'h33), 32'h1018, u_div, 32'h77, 5'd9, 1'b1, 1'b0};
        rows[7]  = '{encode_word(7'h09, 3'd1, 5'd10, 7'h37), 32'h101c, u_alu, 32'h12345000,
                     5'd10, 1'b1, 1'b0};
        rows[8]  = '{encode_word(7'h00, 3'd0, 5'd11, 7'h33), 32'h1020, u_alu, 32'h88, 5'd11, 1'b1, 1'b0};
        rows[9]  = '{encode_word(7'h00, 3'd0, 5'd4, 7'h63), 32'h1024, u_branch, 32'h2000,
                     5'd4, 1'b0, 1'b0};
        rows[10] = '{encode_word(7'h00, 3'd0, 5'd12, 7'h33), 32'h1028, u_alu, 32'h99, 5'd12, 1'b1, 1'b1};
        rows[11] = '{encode_word(7'h00, 3'd0, 5'd13, 7'h33), 32'h102c, u_alu, 32'haa, 5'd13, 1'b1, 1'b1};
        rows[12] = '{encode_word(7'h00, 3'd0, 5'd12, 7'h33), 32'h2000, u_alu, 32'hbb, 5'd12, 1'b1, 1'b0};
        rows[13] = '{encode_word(7'h20, 3'd0, 5'd14, 7'h33), 32'h2004, u_alu, 32'hcc, 5'd14, 1'b1, 1'b0};
        for (int k = 0; k < depth; k++) begin
            rows[n_fixed + k] = '{encode_word(7'h00, 3'd0, 5'(16 + k), 7'h33),
                                  32'h3000 + 32'(4 * k), u_alu, 32'h5000 + 32'(k),
                                  5'(16 + k), 1'b1, 1'b0};
        end
    endtask

    initial begin
        rst      = 1'b1;
        instr    = '0;
        pc       = '0;
        alu_res  = '0;
        mul_res  = '0;
        div_res  = '0;
        redirect = '0;
        rd_addr  = '0;
        lfsr     = 16'd7860;
        foreach (exp_regs[i]) begin
            exp_regs[i] = '0;
        end
        fill_table();
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        check_flag(commit.valid, 1'b0, "commit.valid after reset");
        check_flag(full, 1'b0, "full after reset");
        check_all_regs();

        dispatch_rows(0, 7, 1'b1);   // Mixed units with bubbles in between
        complete_shuffled(0, 7);
        wait_queue(0);
        dispatch_rows(8, 11, 1'b0);  // Taken branch kills rows 10 and 11
        complete_shuffled(8, 11);
        wait_queue(0);
        dispatch_rows(12, 13, 1'b0); // Fetch resumes at the target
        complete_shuffled(12, 13);
        wait_queue(0);

        // Fill every slot before any completion
        dispatch_rows(n_fixed, n_rows - 1, 1'b0);
        check_flag(full, 1'b1, "full with every slot taken");
        complete(n_fixed);
        wait_queue(depth - 1);
        check_flag(full, 1'b0, "full after the first commit");
        complete_shuffled(n_fixed + 1, n_rows - 1);
        wait_queue(0);

        repeat (4) @(negedge clk); // Room for a stray commit to show up
        check_all_regs();
        if (rob_core_top_inst.reorder_buffer_inst.rob_core_chk_inst.fails == 0) begin
            $display("All tests passed");
            $finish;
        end else begin
            $display("Bound assertions reported %0d failures",
                     rob_core_top_inst.reorder_buffer_inst.rob_core_chk_inst.fails);
            stop_run();
        end
    end

endmodule

`default_nettype wire

// File: build.f
rob_pkg.sv
rob_dispatch.sv
reorder_buffer.sv
rob_commit.sv
rob_core_top.sv
rob_core_chk.sv
tb_rob_core.sv

// File: Bender.yml
package:
  name: rob_core

sources:
  - files:
      - rob_pkg.sv
      - rob_dispatch.sv
      - reorder_buffer.sv
      - rob_commit.sv
      - rob_core_top.sv
  - target: test
    files:
      - rob_core_chk.sv
      - tb_rob_core.sv
